/* include/cnn_config.svh */
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// word widths
`define CNN_DATA_W 16
`define CNN_ADDR_W 16

// memory map, word addresses
`define CNN_KERNEL_BASE 0
`define CNN_IMG_BASE 18

// image row stride in words
`define CNN_IMG_W 10

// 3x3 conv over a 10x10 image gives 8x8
`define CNN_CONV_OUT 8

// 2x2 stride-2 pooling of the 8x8 result
`define CNN_POOL_OUT 4

`define CNN_TAPS 9

`endif

/* rtl/cnn_pkg.sv */
`default_nettype none

`include "cnn_config.svh"

package cnn_pkg;

    typedef logic signed [`CNN_DATA_W-1:0] pixel_t;

    typedef logic [`CNN_ADDR_W-1:0] addr_t;

    // tap 0 is the top-left pixel, row-major after that
    typedef pixel_t [`CNN_TAPS-1:0] taps_t;

    typedef enum logic [3:0] {
        IDLE,
        LOAD_KERNEL,
        LOAD_PATCH,
        CONV_CALC,
        CONV_WRITE,
        LOAD_POOL,
        POOL_CALC,
        POOL_WRITE,
        FINISH
    } seq_state_t;

endpackage

`default_nettype wire

/* rtl/mem_req_if.sv */
`default_nettype none

// one word per request, ack closes it
interface mem_req_if;

    logic req;
    logic we;
    cnn_pkg::addr_t addr;
    cnn_pkg::pixel_t wdata;
    cnn_pkg::pixel_t rdata;
    logic ack;

    modport seq (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport bus (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

/* rtl/wb_master.sv */
`default_nettype none

module wb_master (
    input  wire                   CLK,
    input  wire                   reset_i,
    mem_req_if.bus                mem,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic                  wb_we_o,
    output cnn_pkg::addr_t        wb_adr_o,
    output cnn_pkg::pixel_t       wb_dat_o,
    input  wire cnn_pkg::pixel_t  wb_dat_i,
    input  wire                   wb_ack_i
);

    logic cyc_q;
    logic we_q;
    logic ack_q;
    logic launch;
    cnn_pkg::addr_t adr_q;
    cnn_pkg::pixel_t dat_q;
    cnn_pkg::pixel_t rdata_q;

    // the ack cycle doubles as the idle gap, so a held req is not relaunched
    assign launch = mem.req && !cyc_q && !ack_q;

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (cyc_q) begin
                if (wb_ack_i) begin
                    cyc_q <= 1'b0;
                    we_q  <= 1'b0;
                    ack_q <= 1'b1;
                end
            end else if (launch) begin
                cyc_q <= 1'b1;
                we_q  <= mem.we;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (launch) begin
            adr_q <= mem.addr;
            dat_q <= mem.wdata;
        end
        if (cyc_q && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o  = cyc_q;
    assign wb_stb_o  = cyc_q;
    assign wb_we_o   = we_q;
    assign wb_adr_o  = adr_q;
    assign wb_dat_o  = dat_q;
    assign mem.ack   = ack_q;
    assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/conv_mac.sv */
`default_nettype none

`include "cnn_config.svh"

module conv_mac (
    input  wire                  CLK,
    input  wire                  reset_i,
    input  wire                  calc_i,
    input  wire cnn_pkg::taps_t  kern_i,
    input  wire cnn_pkg::taps_t  taps_i,
    output cnn_pkg::pixel_t      result_o
);

    localparam int ACC_W = 2 * `CNN_DATA_W;

    logic signed [ACC_W-1:0] acc_w;

    // full-width products, only the low word is kept
    always_comb begin
        acc_w = '0;
        for (int i = 0; i < `CNN_TAPS; i++) begin
            acc_w = acc_w + ACC_W'(kern_i[i]) * ACC_W'(taps_i[i]);
        end
    end

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            result_o <= '0;
        end else if (calc_i) begin
            result_o <= acc_w[`CNN_DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* rtl/max_pool4.sv */
`default_nettype none

module max_pool4 (
    input  wire                  CLK,
    input  wire                  reset_i,
    input  wire                  calc_i,
    input  wire cnn_pkg::taps_t  taps_i,
    output cnn_pkg::pixel_t      result_o
);

    cnn_pkg::pixel_t top_max;
    cnn_pkg::pixel_t bot_max;
    cnn_pkg::pixel_t win_max;

    // taps 0,1 top row, 2,3 bottom row
    always_comb begin
        top_max = (taps_i[0] > taps_i[1]) ? taps_i[0] : taps_i[1];
        bot_max = (taps_i[2] > taps_i[3]) ? taps_i[2] : taps_i[3];
        win_max = (top_max > bot_max) ? top_max : bot_max;
    end

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            result_o <= '0;
        end else if (calc_i) begin
            result_o <= win_max;
        end
    end

endmodule

`default_nettype wire

/* rtl/layer_sequencer.sv */
`default_nettype none

`include "cnn_config.svh"

module layer_sequencer (
    input  wire                   CLK,
    input  wire                   reset_i,
    input  wire                   start_i,
    input  wire cnn_pkg::pixel_t  conv_res_i,
    input  wire cnn_pkg::pixel_t  pool_res_i,
    output logic                  done_o,
    output cnn_pkg::taps_t        taps_o,
    output cnn_pkg::taps_t        kern_o,
    output logic                  conv_calc_o,
    output logic                  pool_calc_o,
    mem_req_if.seq                mem
);

    localparam int TAP_W = $clog2(`CNN_TAPS);
    localparam int POS_W = $clog2(`CNN_CONV_OUT);

    localparam logic [TAP_W-1:0] LAST_TAP  = TAP_W'(`CNN_TAPS - 1);
    localparam logic [TAP_W-1:0] LAST_POOL = TAP_W'(3);
    localparam logic [POS_W-1:0] LAST_CONV_POS = POS_W'(`CNN_CONV_OUT - 1);
    localparam logic [POS_W-1:0] LAST_POOL_POS = POS_W'(`CNN_POOL_OUT - 1);

    cnn_pkg::seq_state_t state_q;
    logic [TAP_W-1:0] tap_q;
    logic [POS_W-1:0] row_q;
    logic [POS_W-1:0] col_q;
    logic req_q;
    logic we_q;
    logic conv_calc_q;
    logic pool_calc_q;
    cnn_pkg::taps_t kern_q;
    cnn_pkg::taps_t win_q;
    logic [1:0] tap_r;
    logic [1:0] tap_c;
    logic [POS_W:0] r_eff;
    logic [POS_W:0] c_eff;
    cnn_pkg::addr_t addr_w;

    // tap index to offset inside the window
    always_comb begin
        if (state_q == cnn_pkg::LOAD_POOL) begin
            tap_r = {1'b0, tap_q[1]};
            tap_c = {1'b0, tap_q[0]};
        end else begin
            case (tap_q)
                4'd0, 4'd1, 4'd2: tap_r = 2'd0;
                4'd3, 4'd4, 4'd5: tap_r = 2'd1;
                default:          tap_r = 2'd2;
            endcase
            case (tap_q)
                4'd0, 4'd3, 4'd6: tap_c = 2'd0;
                4'd1, 4'd4, 4'd7: tap_c = 2'd1;
                default:          tap_c = 2'd2;
            endcase
        end
    end

    // write states address the window's own pixel
    always_comb begin
        r_eff = {1'b0, row_q};
        c_eff = {1'b0, col_q};
        case (state_q)
            cnn_pkg::LOAD_PATCH: begin
                r_eff = {1'b0, row_q} + {2'b00, tap_r};
                c_eff = {1'b0, col_q} + {2'b00, tap_c};
            end
            cnn_pkg::LOAD_POOL: begin
                r_eff = {row_q, 1'b0} + {2'b00, tap_r};
                c_eff = {col_q, 1'b0} + {2'b00, tap_c};
            end
            default: begin
            end
        endcase
        if (state_q == cnn_pkg::LOAD_KERNEL) begin
            addr_w = cnn_pkg::addr_t'(`CNN_KERNEL_BASE) + cnn_pkg::addr_t'(tap_q);
        end else begin
            addr_w = cnn_pkg::addr_t'(`CNN_IMG_BASE)
                   + cnn_pkg::addr_t'(r_eff) * cnn_pkg::addr_t'(`CNN_IMG_W)
                   + cnn_pkg::addr_t'(c_eff);
        end
    end

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            state_q     <= cnn_pkg::IDLE;
            tap_q       <= '0;
            row_q       <= '0;
            col_q       <= '0;
            req_q       <= 1'b0;
            we_q        <= 1'b0;
            conv_calc_q <= 1'b0;
            pool_calc_q <= 1'b0;
        end else begin
            conv_calc_q <= 1'b0;
            pool_calc_q <= 1'b0;
            case (state_q)
                cnn_pkg::IDLE: begin
                    if (start_i) begin
                        state_q <= cnn_pkg::LOAD_KERNEL;
                        tap_q   <= '0;
                        row_q   <= '0;
                        col_q   <= '0;
                        req_q   <= 1'b1;
                        we_q    <= 1'b0;
                    end
                end
                cnn_pkg::LOAD_KERNEL: begin
                    if (mem.ack) begin
                        if (tap_q == LAST_TAP) begin
                            tap_q   <= '0;
                            state_q <= cnn_pkg::LOAD_PATCH;
                        end else begin
                            tap_q <= tap_q + 1'b1;
                        end
                    end
                end
                cnn_pkg::LOAD_PATCH: begin
                    if (mem.ack) begin
                        if (tap_q == LAST_TAP) begin
                            tap_q       <= '0;
                            req_q       <= 1'b0;
                            conv_calc_q <= 1'b1;
                            state_q     <= cnn_pkg::CONV_CALC;
                        end else begin
                            tap_q <= tap_q + 1'b1;
                        end
                    end
                end
                cnn_pkg::CONV_CALC: begin
                    req_q   <= 1'b1;
                    we_q    <= 1'b1;
                    state_q <= cnn_pkg::CONV_WRITE;
                end
                cnn_pkg::CONV_WRITE: begin
                    if (mem.ack) begin
                        we_q    <= 1'b0;
                        state_q <= cnn_pkg::LOAD_PATCH;
                        if (col_q == LAST_CONV_POS) begin
                            col_q <= '0;
                            if (row_q == LAST_CONV_POS) begin
                                row_q   <= '0;
                                state_q <= cnn_pkg::LOAD_POOL;
                            end else begin
                                row_q <= row_q + 1'b1;
                            end
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                end
                cnn_pkg::LOAD_POOL: begin
                    if (mem.ack) begin
                        if (tap_q == LAST_POOL) begin
                            tap_q       <= '0;
                            req_q       <= 1'b0;
                            pool_calc_q <= 1'b1;
                            state_q     <= cnn_pkg::POOL_CALC;
                        end else begin
                            tap_q <= tap_q + 1'b1;
                        end
                    end
                end
                cnn_pkg::POOL_CALC: begin
                    req_q   <= 1'b1;
                    we_q    <= 1'b1;
                    state_q <= cnn_pkg::POOL_WRITE;
                end
                cnn_pkg::POOL_WRITE: begin
                    if (mem.ack) begin
                        we_q    <= 1'b0;
                        state_q <= cnn_pkg::LOAD_POOL;
                        if (col_q == LAST_POOL_POS) begin
                            col_q <= '0;
                            if (row_q == LAST_POOL_POS) begin
                                row_q   <= '0;
                                req_q   <= 1'b0;
                                state_q <= cnn_pkg::FINISH;
                            end else begin
                                row_q <= row_q + 1'b1;
                            end
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= cnn_pkg::IDLE;
                end
            endcase
        end
    end

    // read data into the indexed tap
    always_ff @(posedge CLK) begin
        if (mem.ack) begin
            if (state_q == cnn_pkg::LOAD_KERNEL) begin
                kern_q[tap_q] <= mem.rdata;
            end else if (state_q == cnn_pkg::LOAD_PATCH || state_q == cnn_pkg::LOAD_POOL) begin
                win_q[tap_q] <= mem.rdata;
            end
        end
    end

    assign mem.req     = req_q;
    assign mem.we      = we_q;
    assign mem.addr    = addr_w;
    assign mem.wdata   = (state_q == cnn_pkg::POOL_WRITE) ? pool_res_i : conv_res_i;
    assign taps_o      = win_q;
    assign kern_o      = kern_q;
    assign conv_calc_o = conv_calc_q;
    assign pool_calc_o = pool_calc_q;
    assign done_o      = (state_q == cnn_pkg::FINISH);

endmodule

`default_nettype wire

/* rtl/cnn_layer_top.sv */
`default_nettype none

module cnn_layer_top (
    input  wire                   CLK,
    input  wire                   reset_i,
    input  wire                   start_i,
    output logic                  done_o,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic                  wb_we_o,
    output cnn_pkg::addr_t        wb_adr_o,
    output cnn_pkg::pixel_t       wb_dat_o,
    input  wire cnn_pkg::pixel_t  wb_dat_i,
    input  wire                   wb_ack_i
);

    mem_req_if mem ();

    cnn_pkg::taps_t taps;
    cnn_pkg::taps_t kern;
    cnn_pkg::pixel_t conv_res;
    cnn_pkg::pixel_t pool_res;
    logic conv_calc;
    logic pool_calc;

    layer_sequencer layer_sequencer_inst (
        .CLK         (CLK),
        .reset_i     (reset_i),
        .start_i     (start_i),
        .conv_res_i  (conv_res),
        .pool_res_i  (pool_res),
        .done_o      (done_o),
        .taps_o      (taps),
        .kern_o      (kern),
        .conv_calc_o (conv_calc),
        .pool_calc_o (pool_calc),
        .mem         (mem.seq)
    );

    wb_master wb_master_inst (
        .CLK      (CLK),
        .reset_i  (reset_i),
        .mem      (mem.bus),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    conv_mac conv_mac_inst (
        .CLK      (CLK),
        .reset_i  (reset_i),
        .calc_i   (conv_calc),
        .kern_i   (kern),
        .taps_i   (taps),
        .result_o (conv_res)
    );

    max_pool4 max_pool4_inst (
        .CLK      (CLK),
        .reset_i  (reset_i),
        .calc_i   (pool_calc),
        .taps_i   (taps),
        .result_o (pool_res)
    );

endmodule

`default_nettype wire

/* tb/clk_gen.sv */
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic reset_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb/cnn_props.sv */
`default_nettype none

module cnn_props (
    input wire                   CLK,
    input wire                   reset_i,
    input wire                   cyc_i,
    input wire                   stb_i,
    input wire                   we_i,
    input wire cnn_pkg::addr_t   adr_i,
    input wire cnn_pkg::pixel_t  dat_i,
    input wire                   ack_i,
    input wire                   done_i
);

    timeunit 1ns;
    timeprecision 100ps;

    stb_needs_cyc: assert property (@(posedge CLK) disable iff (reset_i)
        stb_i |-> cyc_i)
        else $error("stb high without cyc");

    // a waiting request may not change under the slave
    req_held: assert property (@(posedge CLK) disable iff (reset_i)
        (stb_i && !ack_i) |=> (stb_i && $stable(adr_i) && $stable(we_i) && $stable(dat_i)))
        else $error("bus request changed before ack");

    done_single: assert property (@(posedge CLK) disable iff (reset_i)
        done_i |=> !done_i)
        else $error("done_o longer than one cycle");

endmodule

bind cnn_layer_top cnn_props cnn_props_inst (
    .CLK     (CLK),
    .reset_i (reset_i),
    .cyc_i   (wb_cyc_o),
    .stb_i   (wb_stb_o),
    .we_i    (wb_we_o),
    .adr_i   (wb_adr_o),
    .dat_i   (wb_dat_o),
    .ack_i   (wb_ack_i),
    .done_i  (done_o)
);

`default_nettype wire

/* tb/tb_cnn_layer.sv */
`default_nettype none

`include "cnn_config.svh"

module tb_cnn_layer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 256;
    localparam int IMG_WORDS = `CNN_IMG_W * `CNN_IMG_W;
    localparam int DATA_WORDS = `CNN_TAPS + 2 * IMG_WORDS;
    localparam int IMG_LAST = `CNN_IMG_BASE + IMG_WORDS - 1;
    localparam int RUN_TIMEOUT = 20000;
    localparam int EXP_READS = 649;
    localparam int EXP_WRITES = 80;

    logic CLK;
    logic reset_i;
    logic start_i = 1'b0;
    logic done_o;
    logic wb_cyc_o;
    logic wb_stb_o;
    logic wb_we_o;
    cnn_pkg::addr_t wb_adr_o;
    cnn_pkg::pixel_t wb_dat_o;
    cnn_pkg::pixel_t wb_dat_i = '0;
    logic wb_ack_i = 1'b0;

    logic [15:0] testdata [0:DATA_WORDS-1];
    logic [15:0] mem [0:MEM_WORDS-1];
    logic [31:0] rand_state = 32'h70784654;
    int wait_left = 0;
    logic reload_req = 1'b0;
    int reads = 0;
    int writes = 0;
    int bus_errors = 0;
    int done_count = 0;
    logic after_done = 1'b0;
    int monitor_errors = 0;
    int value_errors = 0;
    int other_errors = 0;
    logic timed_out = 1'b0;

    clk_gen clk_gen_inst (
        .clk_o   (CLK),
        .reset_o (reset_i)
    );

    cnn_layer_top cnn_layer_top_inst (
        .CLK      (CLK),
        .reset_i  (reset_i),
        .start_i  (start_i),
        .done_o   (done_o),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // filler outside kernel and image, different at every address
    function automatic logic [15:0] fill_word(input int addr);
        logic [7:0] a;
        a = addr[7:0];
        return 16'hC3A5 ^ {a, ~a};
    endfunction

    function automatic logic [15:0] start_word(input int addr);
        if (addr < `CNN_TAPS) begin
            return testdata[addr];
        end else if (addr >= `CNN_IMG_BASE && addr <= IMG_LAST) begin
            return testdata[`CNN_TAPS + addr - `CNN_IMG_BASE];
        end
        return fill_word(addr);
    endfunction

    function automatic logic [15:0] final_word(input int addr);
        if (addr >= `CNN_IMG_BASE && addr <= IMG_LAST) begin
            return testdata[`CNN_TAPS + IMG_WORDS + addr - `CNN_IMG_BASE];
        end
        return start_word(addr);
    endfunction

    // wishbone slave with 0 to 3 wait states
    always @(posedge CLK) begin
        if (reload_req) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= start_word(i);
            end
        end
        if (reset_i) begin
            wb_ack_i <= 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_left > 0) begin
                wait_left <= wait_left - 1;
            end else begin
                wb_ack_i <= 1'b1;
                rand_state <= next_rand(rand_state);
                wait_left <= int'(next_rand(rand_state) & 32'h3);
                if (wb_we_o) begin
                    writes <= writes + 1;
                    if (wb_adr_o < `CNN_IMG_BASE || wb_adr_o > IMG_LAST) begin
                        $display("write outside the image at address %04h", wb_adr_o);
                        bus_errors <= bus_errors + 1;
                    end else begin
                        mem[wb_adr_o[7:0]] <= wb_dat_o;
                    end
                end else begin
                    reads <= reads + 1;
                    wb_dat_i <= mem[wb_adr_o[7:0]];
                end
            end
        end
    end

    always @(posedge CLK) begin
        if (done_o) begin
            done_count <= done_count + 1;
        end
        if (start_i) begin
            after_done <= 1'b0;
        end else if (done_o) begin
            after_done <= 1'b1;
        end
        if (after_done && wb_cyc_o && !reset_i) begin
            $display("bus cycle after done_o at address %04h", wb_adr_o);
            monitor_errors <= monitor_errors + 1;
        end
    end

    task automatic run_layer(input int run_id);
        int reads0;
        int writes0;
        int done0;
        int cycles;
        logic [15:0] exp;
        reads0 = reads;
        writes0 = writes;
        done0 = done_count;
        @(posedge CLK);
        reload_req <= 1'b1;
        @(posedge CLK);
        reload_req <= 1'b0;
        start_i <= 1'b1;
        @(posedge CLK);
        start_i <= 1'b0;
        repeat (40) @(posedge CLK);
        // stray start while busy
        start_i <= 1'b1;
        @(posedge CLK);
        start_i <= 1'b0;
        cycles = 0;
        while (done_count == done0 && cycles < RUN_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (done_count == done0) begin
            $display("run %0d timed out waiting for done_o", run_id);
            timed_out = 1'b1;
            return;
        end
        // quiet window after done
        repeat (30) @(negedge CLK);
        if (done_count - done0 != 1) begin
            $display("FAIL done_o pulses run %0d: got %0h expected %0h",
                     run_id, done_count - done0, 1);
            value_errors++;
        end
        if (reads - reads0 != EXP_READS) begin
            $display("FAIL bus reads run %0d: got %0h expected %0h",
                     run_id, reads - reads0, EXP_READS);
            value_errors++;
        end
        if (writes - writes0 != EXP_WRITES) begin
            $display("FAIL bus writes run %0d: got %0h expected %0h",
                     run_id, writes - writes0, EXP_WRITES);
            value_errors++;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            exp = final_word(i);
            if (mem[i] !== exp) begin
                $display("FAIL mem[%02h] run %0d: got %04h expected %04h",
                         i, run_id, mem[i], exp);
                value_errors++;
            end
        end
    endtask

    initial begin
        int cycles;
        $readmemh("tb/cnn_testdata.txt", testdata);
        cycles = 0;
        while (reset_i !== 1'b0 && cycles < 100) begin
            @(negedge CLK);
            cycles++;
        end
        if (reset_i !== 1'b0) begin
            $display("reset never released");
            timed_out = 1'b1;
        end else begin
            if (done_o !== 1'b0 || wb_cyc_o !== 1'b0 || wb_stb_o !== 1'b0
                    || wb_we_o !== 1'b0) begin
                $display("outputs not idle after reset");
                other_errors++;
            end
            run_layer(1);
            if (!timed_out) begin
                run_layer(2);
            end
        end
        $display("errors: value %0d, bus %0d, monitor %0d, other %0d, timeout %0d",
                 value_errors, bus_errors, monitor_errors, other_errors, timed_out);
        if (!timed_out && value_errors + bus_errors + monitor_errors + other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
rtl/cnn_pkg.sv
rtl/mem_req_if.sv
rtl/wb_master.sv
rtl/conv_mac.sv
rtl/max_pool4.sv
rtl/layer_sequencer.sv
rtl/cnn_layer_top.sv
tb/clk_gen.sv
tb/cnn_props.sv
tb/tb_cnn_layer.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cnn_layer -f files.f -o sim_cnn > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/sim_cnn > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* tb/cnn_testdata.txt */
// kernel taps 0..8, then the 10x10 input image, then the expected 10x10 image
// after conv and pool, one hex word each, image rows in raster order
0001 0000 0000 0000 FFFF 0000 0000 0000 0002
// input image
0000 FFFF 0002 FFFD 0004 FFFB 0006 FFF9 0008 FFF7
FFF6 000B FFF4 000D FFF2 000F FFF0 0011 FFEE 0013
0014 FFEB 0016 FFE9 0018 FFE7 001A FFE5 001C FFE3
FFE2 001F FFE0 0021 FFDE 0023 FFDC 0025 FFDA 0027
0028 FFD7 002A FFD5 002C FFD3 002E FFD1 0030 FFCF
FFCE 0033 FFCC 0035 FFCA 0037 FFC8 0039 FFC6 003B
003C FFC3 003E FFC1 0040 FFBF 0042 FFBD 0044 FFBB
FFBA 0047 FFB8 0049 FFB6 004B FFB4 004D FFB2 004F
0050 FFAF 0052 FFAD 0054 FFAB 0056 FFA9 0058 FFA7
FFA6 005B FFA4 005D FFA2 005F FFA0 0061 FF9E 0063
// expected image
0037 003B 003F 0043 0029 FFD5 002D FFD1 0008 FFF7
005F 0063 0067 006B FFC3 003F FFBF 0043 FFEE 0013
0087 008B 008F 0093 0051 FFAD 0055 FFA9 001C FFE3
00AF 00B3 00B7 00BB FF9B 0067 FF97 006B FFDA 0027
0071 FF8D 0075 FF89 0079 FF85 007D FF81 0030 FFCF
FF7B 0087 FF77 008B FF73 008F FF6F 0093 FFC6 003B
0099 FF65 009D FF61 00A1 FF5D 00A5 FF59 0044 FFBB
FF53 00AF FF4F 00B3 FF4B 00B7 FF47 00BB FFB2 004F
0050 FFAF 0052 FFAD 0054 FFAB 0056 FFA9 0058 FFA7
FFA6 005B FFA4 005D FFA2 005F FFA0 0061 FF9E 0063
